/* soc_periph.f */
source/soc_pkg.sv
source/address_decoder.sv
source/bus_ram.sv
source/peripheral_mult.sv
source/peripheral_gpio.sv
source/read_select.sv
source/soc_periph.sv
test/soc_periph_checker.sv
test/soc_periph_tb.sv

/* source/address_decoder.sv */
`timescale 1ns/100ps

module address_decoder
  import soc_pkg::*;
(
  input  logic [31:0]          mem_addr,
  output logic [n_regions-1:0] cs
);

  logic       upper_zero;
  logic [2:0] region;

  assign upper_zero = (mem_addr[31:23] == 9'd0);
  assign region     = mem_addr[22:20];

  // one-hot select, nothing for unmapped space
  always_comb begin
    cs = '0;
    if (upper_zero) begin
      case (region)
        3'(region_ram):  cs[cs_ram]  = 1'b1;
        3'(region_mult): cs[cs_mult] = 1'b1;
        3'(region_gpio): cs[cs_gpio] = 1'b1;
        default:         cs = '0;  // hole in the map
      endcase
    end
  end

endmodule

/* source/bus_ram.sv */
`timescale 1ns/100ps

module bus_ram #(
  parameter int ram_words = 1024
) (
  input  logic        clk,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wmask,
  input  logic        mem_rstrb,
  output logic [31:0] rdata
);

  localparam int addr_w = (ram_words > 1) ? $clog2(ram_words) : 1;

  logic [31:0]       mem [ram_words];
  logic [29:0]       word_addr;
  logic [29:0]       word_mod;
  logic [addr_w-1:0] index;

  // byte address to word index, wrapped onto the array depth
  assign word_addr = mem_addr[31:2];
  assign word_mod  = word_addr % 30'(ram_words);
  assign index     = word_mod[addr_w-1:0];

  // each lane written only where its mask bit is set
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (mem_wmask[lane]) begin
        mem[index][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rstrb) begin
      rdata <= mem[index];  // valid the cycle after the strobe
    end
  end

endmodule

/* source/peripheral_gpio.sv */
`timescale 1ns/100ps

module peripheral_gpio
  import soc_pkg::*;
#(
  parameter int gpio_width = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [4:0]            addr,
  input  logic [31:0]           wdata,
  input  logic                  wr,
  input  logic                  rd,
  input  logic [gpio_width-1:0] switches,
  output logic [gpio_width-1:0] leds,
  output logic [31:0]           rdata
);

  logic [gpio_width-1:0] sw_meta;  // first stage, may go metastable
  logic [gpio_width-1:0] sw_sync;

  always_ff @(posedge clk) begin
    if (reset) begin
      leds <= '0;
    end else if (wr && (addr == 5'(gpio_reg_leds))) begin
      leds <= wdata[gpio_width-1:0];
    end
  end

  // two-flop synchronizer for the asynchronous switch pins
  always_ff @(posedge clk) begin
    if (reset) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= switches;
      sw_sync <= sw_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (addr)
        5'(gpio_reg_leds):     rdata <= 32'(leds);
        5'(gpio_reg_switches): rdata <= 32'(sw_sync);
        default:               rdata <= '0;
      endcase
    end
  end

endmodule

/* source/peripheral_mult.sv */
`timescale 1ns/100ps

module peripheral_mult
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  addr,
  input  logic [15:0] wdata,
  input  logic        wr,
  input  logic        rd,
  output logic [31:0] rdata
);

  localparam int cnt_w = (mult_cycles > 1) ? $clog2(mult_cycles) : 1;

  logic [15:0]      op_a;
  logic [15:0]      op_b;
  logic [31:0]      mcand;   // multiplicand, moves left one bit per step
  logic [15:0]      mplier;  // multiplier, lsb decides the add
  logic [31:0]      acc;
  logic [31:0]      acc_next;
  logic [31:0]      result;
  logic [cnt_w-1:0] step;
  logic             busy;
  logic             done;
  logic             start;
  logic             last_step;

  // starts and operand writes are dropped while a multiply runs
  assign start     = wr && !busy && (addr == 5'(mult_reg_ctrl)) && wdata[0];
  assign last_step = busy && (step == cnt_w'(mult_cycles - 1));
  assign acc_next  = mplier[0] ? acc + mcand : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;  // cleared only by a new start
      step <= '0;
    end else if (busy) begin
      step <= step + 1'b1;
      if (last_step) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // operand registers
  always_ff @(posedge clk) begin
    if (wr && !busy) begin
      if (addr == 5'(mult_reg_a)) op_a <= wdata;
      if (addr == 5'(mult_reg_b)) op_b <= wdata;
    end
  end

  // shift-add datapath
  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= {16'd0, op_a};
      mplier <= op_b;
      acc    <= '0;
    end else if (busy) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      acc    <= acc_next;
      if (last_step) begin
        result <= acc_next;  // final partial sum is the product
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (addr)
        5'(mult_reg_a):      rdata <= {16'd0, op_a};
        5'(mult_reg_b):      rdata <= {16'd0, op_b};
        5'(mult_reg_status): rdata <= {30'd0, busy, done};
        5'(mult_reg_result): rdata <= result;
        default:             rdata <= '0;  // ctrl is write only
      endcase
    end
  end

endmodule

/* source/read_select.sv */
`timescale 1ns/100ps

module read_select
  import soc_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [n_regions-1:0] cs,
  input  logic                 mem_rstrb,
  input  logic [31:0]          ram_rdata,
  input  logic [31:0]          mult_rdata,
  input  logic [31:0]          gpio_rdata,
  output logic [31:0]          mem_rdata
);

  logic [n_regions-1:0] sel_q;  // region of the last read

  // the peripherals register their data on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_q <= '0;
    end else if (mem_rstrb) begin
      sel_q <= cs;
    end
  end

  // sel_q is one-hot or zero
  always_comb begin
    mem_rdata = '0;  // unmapped reads return zero
    if (sel_q[cs_ram]) begin
      mem_rdata = ram_rdata;
    end else if (sel_q[cs_mult]) begin
      mem_rdata = mult_rdata;
    end else if (sel_q[cs_gpio]) begin
      mem_rdata = gpio_rdata;
    end
  end

endmodule

/* source/soc_periph.sv */
`timescale 1ns/100ps

module soc_periph
  import soc_pkg::*;
#(
  parameter int ram_words  = 1024,
  parameter int gpio_width = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [31:0]           mem_addr,
  input  logic [31:0]           mem_wdata,
  input  logic [3:0]            mem_wmask,
  input  logic                  mem_rstrb,
  output logic [31:0]           mem_rdata,
  input  logic [gpio_width-1:0] switches,
  output logic [gpio_width-1:0] leds
);

  logic [n_regions-1:0] cs;
  logic                 wr;
  logic [3:0]           ram_wmask;
  logic                 ram_rstrb;
  logic                 mult_wr;
  logic                 mult_rd;
  logic                 gpio_wr;
  logic                 gpio_rd;
  logic [31:0]          ram_rdata;
  logic [31:0]          mult_rdata;
  logic [31:0]          gpio_rdata;

  assign wr = |mem_wmask;  // any lane set means a write

  // strobes reach a peripheral only through its select
  assign ram_wmask = {4{cs[cs_ram]}} & mem_wmask;
  assign ram_rstrb = cs[cs_ram] & mem_rstrb;
  assign mult_wr   = cs[cs_mult] & wr;
  assign mult_rd   = cs[cs_mult] & mem_rstrb;
  assign gpio_wr   = cs[cs_gpio] & wr;
  assign gpio_rd   = cs[cs_gpio] & mem_rstrb;

  address_decoder u_decoder (
    .mem_addr (mem_addr),
    .cs       (cs)
  );

  bus_ram #(
    .ram_words (ram_words)
  ) u_ram (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (ram_wmask),
    .mem_rstrb (ram_rstrb),
    .rdata     (ram_rdata)
  );

  peripheral_mult u_mult (
    .clk   (clk),
    .reset (reset),
    .addr  (mem_addr[4:0]),
    .wdata (mem_wdata[15:0]),  // operands are 16 bits
    .wr    (mult_wr),
    .rd    (mult_rd),
    .rdata (mult_rdata)
  );

  peripheral_gpio #(
    .gpio_width (gpio_width)
  ) u_gpio (
    .clk      (clk),
    .reset    (reset),
    .addr     (mem_addr[4:0]),
    .wdata    (mem_wdata),
    .wr       (gpio_wr),
    .rd       (gpio_rd),
    .switches (switches),
    .leds     (leds),
    .rdata    (gpio_rdata)
  );

  read_select u_read_select (
    .clk        (clk),
    .reset      (reset),
    .cs         (cs),
    .mem_rstrb  (mem_rstrb),
    .ram_rdata  (ram_rdata),
    .mult_rdata (mult_rdata),
    .gpio_rdata (gpio_rdata),
    .mem_rdata  (mem_rdata)
  );

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

  // number of decoded bus regions
  localparam int n_regions = 3;

  // bit positions inside the chip-select vector
  localparam int cs_ram  = 0;
  localparam int cs_mult = 1;
  localparam int cs_gpio = 2;

  // region field values, compared on mem_addr[22:20]
  localparam int region_ram  = 0;
  localparam int region_mult = 3;
  localparam int region_gpio = 4;

  // multiplier register byte offsets, compared on mem_addr[4:0]
  localparam int mult_reg_a      = 0;   // operand a, low 16 bits
  localparam int mult_reg_b      = 4;   // operand b, low 16 bits
  localparam int mult_reg_ctrl   = 8;   // bit 0 starts a multiply
  localparam int mult_reg_status = 12;  // bit 1 busy, bit 0 done
  localparam int mult_reg_result = 16;  // 32-bit product

  // gpio register byte offsets
  localparam int gpio_reg_leds     = 0;
  localparam int gpio_reg_switches = 4;  // read only

  // one shift-add step per operand bit
  localparam int mult_cycles = 16;

endpackage

/* test/soc_periph_checker.sv */
`timescale 1ns/100ps

module soc_periph_checker
  import soc_pkg::*;
#(
  parameter int gpio_width = 8
) (
  input logic                  clk,
  input logic                  reset,
  input logic [n_regions-1:0]  cs,
  input logic                  busy,
  input logic                  done,
  input logic                  gpio_wr,
  input logic [gpio_width-1:0] leds
);

  // at most one region answers any address
  cs_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(cs))
    else $error("chip select is not one-hot: %b", cs);

  busy_done_exclusive: assert property (@(posedge clk) disable iff (reset) !(busy && done))
    else $error("multiplier busy and done are high together");

  // one busy window per start, no early or late finish
  busy_length: assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> busy [*mult_cycles] ##1 !busy)
    else $error("multiplier busy window is not %0d cycles", mult_cycles);

  leds_stable: assert property (@(posedge clk) disable iff (reset)
    !gpio_wr |=> $stable(leds))
    else $error("leds changed without a gpio write");

endmodule

bind soc_periph soc_periph_checker #(
  .gpio_width (gpio_width)
) i_checker (
  .clk     (clk),
  .reset   (reset),
  .cs      (cs),
  .busy    (u_mult.busy),
  .done    (u_mult.done),
  .gpio_wr (gpio_wr),
  .leds    (leds)
);

/* test/soc_periph_tb.sv */
`timescale 1ns/100ps

module soc_periph_tb
  import soc_pkg::*;
();

  localparam int ram_words    = 1024;
  localparam int gpio_width   = 8;
  localparam int reset_cycles = 4;

  localparam int op_write  = 0;
  localparam int op_read   = 1;  // read and compare
  localparam int op_poll   = 2;  // read status until done
  localparam int op_switch = 3;  // drive switches and wait two clocks

  localparam logic [31:0] mult_base = 32'(region_mult) << 20;
  localparam logic [31:0] gpio_base = 32'(region_gpio) << 20;

  logic                  clk;
  logic                  reset;
  logic [31:0]           mem_addr;
  logic [31:0]           mem_wdata;
  logic [3:0]            mem_wmask;
  logic                  mem_rstrb;
  logic [31:0]           mem_rdata;
  logic [gpio_width-1:0] switches;
  logic [gpio_width-1:0] leds;

  // stimulus table held as parallel queues
  int          tab_op[$];
  logic [31:0] tab_addr[$];
  logic [31:0] tab_data[$];
  logic [3:0]  tab_mask[$];
  logic [31:0] tab_exp[$];
  bit          tab_fixed[$];  // expected value given in the row

  // reference model of the memory map
  logic [31:0]           ram_model [int];
  logic [15:0]           m_a;
  logic [15:0]           m_b;
  logic [31:0]           m_prod;
  logic [31:0]           m_result;
  bit                    m_busy;
  bit                    m_done;
  logic [gpio_width-1:0] m_leds;
  logic [gpio_width-1:0] m_switches;

  int cycle_count;
  int cycle_limit;

  soc_periph #(
    .ram_words  (ram_words),
    .gpio_width (gpio_width)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rstrb (mem_rstrb),
    .mem_rdata (mem_rdata),
    .switches  (switches),
    .leds      (leds)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("hang: table did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] mask, input logic [31:0] exp, input bit fixed);
    tab_op.push_back(op);
    tab_addr.push_back(addr);
    tab_data.push_back(data);
    tab_mask.push_back(mask);
    tab_exp.push_back(exp);
    tab_fixed.push_back(fixed);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s returned %08h, expected %08h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // model write under the decode and register rules of the map
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
    int          idx;
    logic [31:0] word;
    if (addr[31:23] != 9'd0 || mask == 4'd0) return;
    case (addr[22:20])
      3'(region_ram): begin
        idx  = int'(addr[31:2] % ram_words);  // wraps onto the depth
        word = ram_model.exists(idx) ? ram_model[idx] : 32'hx;
        for (int lane = 0; lane < 4; lane++) begin
          if (mask[lane]) word[lane*8 +: 8] = data[lane*8 +: 8];
        end
        ram_model[idx] = word;
      end
      3'(region_mult): begin
        if (!m_busy) begin  // writes while busy are dropped
          if (addr[4:0] == 5'(mult_reg_a)) m_a = data[15:0];
          if (addr[4:0] == 5'(mult_reg_b)) m_b = data[15:0];
          if (addr[4:0] == 5'(mult_reg_ctrl) && data[0]) begin
            m_prod = {16'd0, m_a} * {16'd0, m_b};
            m_busy = 1'b1;
            m_done = 1'b0;
          end
        end
      end
      3'(region_gpio): begin
        if (addr[4:0] == 5'(gpio_reg_leds)) m_leds = data[gpio_width-1:0];
      end
      default: ;
    endcase
  endtask

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    int idx;
    idx = int'(addr[31:2] % ram_words);
    if (addr[31:23] != 9'd0) return 32'd0;
    case (addr[22:20])
      3'(region_ram):  return ram_model.exists(idx) ? ram_model[idx] : 32'hx;
      3'(region_mult): begin
        case (addr[4:0])
          5'(mult_reg_a):      return {16'd0, m_a};
          5'(mult_reg_b):      return {16'd0, m_b};
          5'(mult_reg_status): return {30'd0, m_busy, m_done};
          5'(mult_reg_result): return m_result;
          default:             return 32'd0;
        endcase
      end
      3'(region_gpio): begin
        if (addr[4:0] == 5'(gpio_reg_leds)) return 32'(m_leds);
        if (addr[4:0] == 5'(gpio_reg_switches)) return 32'(m_switches);
        return 32'd0;
      end
      default: return 32'd0;
    endcase
  endfunction

  // one bus cycle entered and left 1 ns after a rising edge
  task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask, input logic rstrb);
    mem_addr  = addr;
    mem_wdata = data;
    mem_wmask = mask;
    mem_rstrb = rstrb;
    @(posedge clk);
    #1;
    mem_wmask = 4'd0;
    mem_rstrb = 1'b0;
  endtask

  task automatic build_table();
    logic [31:0] ram_addrs [4];
    logic [15:0] a0;
    logic [15:0] b0;
    ram_addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0100, 32'h0000_0ffc};
    add_row(op_read, 32'h0010_0000, 32'd0, 4'd0, 32'd0, 1'b1);  // hole in the map
    for (int w = 0; w < 4; w++) add_row(op_write, ram_addrs[w], $urandom, 4'hf, 0, 0);
    for (int w = 0; w < 4; w++) add_row(op_read, ram_addrs[w], 0, 0, 0, 0);
    add_row(op_write, 32'h0000_1000, $urandom, 4'hf, 0, 0);  // aliases word 0
    add_row(op_read, 32'h0000_0000, 0, 0, 0, 0);
    add_row(op_write, 32'h0000_0004, $urandom, 4'b0101, 0, 0);
    add_row(op_read, 32'h0000_0004, 0, 0, 0, 0);
    add_row(op_write, 32'h0000_0004, $urandom, 4'b1000, 0, 0);
    add_row(op_read, 32'h0000_0004, 0, 0, 0, 0);
    add_row(op_write, 32'h0000_0004, $urandom, 4'b0010, 0, 0);
    add_row(op_read, 32'h0000_0004, 0, 0, 0, 0);
    // largest operands first
    add_row(op_write, mult_base + mult_reg_a, 32'h0000_ffff, 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_b, 32'h0000_ffff, 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_ctrl, 32'd1, 4'hf, 0, 0);
    add_row(op_poll, mult_base + mult_reg_status, 0, 0, 0, 0);
    add_row(op_read, mult_base + mult_reg_status, 0, 0, 32'd1, 1'b1);
    add_row(op_read, mult_base + mult_reg_result, 0, 0, 32'hfffe_0001, 1'b1);
    a0 = 16'($urandom);
    b0 = 16'($urandom);
    add_row(op_write, mult_base + mult_reg_a, 32'(a0), 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_b, 32'(b0), 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_ctrl, 32'd1, 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_a, 32'(~a0), 4'hf, 0, 0);  // ignored while busy
    add_row(op_write, mult_base + mult_reg_b, 32'(~b0), 4'hf, 0, 0);
    add_row(op_write, mult_base + mult_reg_ctrl, 32'd1, 4'hf, 0, 0);
    add_row(op_poll, mult_base + mult_reg_status, 0, 0, 0, 0);
    add_row(op_read, mult_base + mult_reg_result, 0, 0, 0, 0);
    add_row(op_read, mult_base + mult_reg_a, 0, 0, 0, 0);
    add_row(op_read, mult_base + mult_reg_b, 0, 0, 0, 0);
    add_row(op_write, gpio_base + gpio_reg_leds, $urandom, 4'hf, 0, 0);
    add_row(op_read, gpio_base + gpio_reg_leds, 0, 0, 0, 0);
    add_row(op_switch, 0, $urandom, 0, 0, 0);
    add_row(op_read, gpio_base + gpio_reg_switches, 0, 0, 0, 0);
    add_row(op_write, gpio_base + gpio_reg_leds, $urandom, 4'b0001, 0, 0);
    add_row(op_read, gpio_base + gpio_reg_leds, 0, 0, 0, 0);
    add_row(op_write, 32'h0080_0000, $urandom, 4'hf, 0, 0);  // upper bits set
    add_row(op_read, 32'h0080_0000, 0, 0, 32'd0, 1'b1);
    add_row(op_read, 32'h0050_0000, 0, 0, 32'd0, 1'b1);
    add_row(op_read, mult_base + 32'd20, 0, 0, 32'd0, 1'b1);
    add_row(op_read, mult_base + mult_reg_ctrl, 0, 0, 32'd0, 1'b1);
    add_row(op_read, gpio_base + 32'd8, 0, 0, 32'd0, 1'b1);
  endtask

  task automatic run_row(input int i);
    logic [31:0] exp_val;
    bit          done_seen;
    case (tab_op[i])
      op_write: begin
        bus_cycle(tab_addr[i], tab_data[i], tab_mask[i], 1'b0);
        model_write(tab_addr[i], tab_data[i], tab_mask[i]);
      end
      op_read: begin
        exp_val = tab_fixed[i] ? tab_exp[i] : model_read(tab_addr[i]);
        bus_cycle(tab_addr[i], 32'd0, 4'd0, 1'b1);
        check_value($sformatf("row %0d read %08h", i, tab_addr[i]), mem_rdata, exp_val);
      end
      op_poll: begin
        done_seen = 1'b0;
        while (!done_seen) begin  // the cycle limit catches a stuck multiplier
          bus_cycle(tab_addr[i], 32'd0, 4'd0, 1'b1);
          done_seen = mem_rdata[0];
        end
        m_busy   = 1'b0;
        m_done   = 1'b1;
        m_result = m_prod;
      end
      op_switch: begin
        switches   = tab_data[i][gpio_width-1:0];
        m_switches = tab_data[i][gpio_width-1:0];
        repeat (2) @(posedge clk);
        #1;
      end
      default: ;
    endcase
    check_value($sformatf("row %0d leds", i), 32'(leds), 32'(m_leds));
  endtask

  initial begin
    void'($urandom(32'h88af_afbb));
    clk         = 1'b0;
    reset       = 1'b1;
    mem_addr    = 32'd0;
    mem_wdata   = 32'd0;
    mem_wmask   = 4'd0;
    mem_rstrb   = 1'b0;
    switches    = '0;
    m_busy      = 1'b0;
    m_done      = 1'b0;
    m_leds      = '0;
    m_switches  = '0;
    cycle_count = 0;
    build_table();
    cycle_limit = 40 * tab_op.size() + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("mem_rdata after reset", mem_rdata, 32'd0);
    check_value("leds after reset", 32'(leds), 32'd0);
    for (int i = 0; i < tab_op.size(); i++) begin
      run_row(i);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
